// File: eg_pkg.sv
/*
 * Shared types for the four-slot envelope generator.
 * Configuration register image is fixed at one 32-bit word per slot.
 * AXI4-Lite widths are narrow on purpose: 16-bit address, 32-bit data.
 */
package eg_pkg;

    // ==================================================
    // Envelope geometry
    // ==================================================
    localparam int NUM_SLOTS = 4;                      // Operator slots in one sweep.
    localparam int SLOT_W    = 2;
    localparam int LEVEL_W   = 10;                     // Attenuation, 0 = loudest.
    localparam int CNT_W     = 15;                     // Sweep counter width.
    localparam logic [LEVEL_W-1:0] LEVEL_MAX = 10'h3FF;
    localparam logic [SLOT_W-1:0]  LAST_SLOT = SLOT_W'(NUM_SLOTS - 1);

    // ==================================================
    // AXI4-Lite
    // ==================================================
    localparam int AXIL_ADDR_W = 16;
    localparam int AXIL_DATA_W = 32;
    localparam int AXIL_STRB_W = AXIL_DATA_W / 8;
    localparam int unsigned REG_SPAN = NUM_SLOTS * 4;  // One word per slot.
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [1:0] {
        ATTACK,
        DECAY,
        SUSTAIN,
        RELEASE
    } eg_phase_e;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESP,
        READ_RESP
    } axil_state_e;

    // Image: ar 3:0, dr 7:4, sl 11:8, rr 15:12, ksr 16, key_on 31.
    typedef struct packed {
        logic [3:0] ar;
        logic [3:0] dr;
        logic [3:0] sl;     // Sustain level, in steps of 32.
        logic [3:0] rr;
        logic       ksr;    // Low bit of the effective rate.
        logic       key_on;
    } slot_cfg_t;

    typedef struct packed {
        logic                valid;
        logic [SLOT_W-1:0]   slot;
        eg_phase_e           phase;
        logic [LEVEL_W-1:0]  level;
    } eg_beat_t;

    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] aw_addr;
        logic                   aw_valid;
        logic [AXIL_DATA_W-1:0] w_data;
        logic [AXIL_STRB_W-1:0] w_strb;
        logic                   w_valid;
        logic                   b_ready;
        logic [AXIL_ADDR_W-1:0] ar_addr;
        logic                   ar_valid;
        logic                   r_ready;
    } axil_req_t;

    typedef struct packed {
        logic                   aw_ready;
        logic                   w_ready;
        logic [1:0]             b_resp;
        logic                   b_valid;
        logic                   ar_ready;
        logic [AXIL_DATA_W-1:0] r_data;
        logic [1:0]             r_resp;
        logic                   r_valid;
    } axil_rsp_t;

endpackage

// File: eg_pure.sv
/*
 * One attenuation step for a single slot, purely combinational.
 * Attack moves toward 0, everything else moves toward LEVEL_MAX.
 * No SSG scaling of the decay increment.
 */
`timescale 1ns/1ps

module eg_pure (
    input  logic                       attack,
    input  logic                       step,
    input  logic [4:0]                 rate,    // Effective rate, 0..31.
    input  logic [eg_pkg::LEVEL_W-1:0] eg_in,
    input  logic                       sum_up,
    output logic [eg_pkg::LEVEL_W-1:0] eg_pure
);
    import eg_pkg::*;

    logic [3:0]         dr_sum;
    logic [LEVEL_W:0]   dr_result;  // Extra bit flags overflow.
    logic [LEVEL_W-3:0] ar_sum0;
    logic [LEVEL_W-2:0] ar_sum1;
    logic [LEVEL_W-1:0] ar_sum;
    logic [LEVEL_W:0]   ar_result;  // Extra bit flags underflow.
    logic [LEVEL_W-1:0] eg_held;

    // Decay increment, doubles per rate above 11.
    always_comb begin
        case (rate[4:1])
            4'd12:   dr_sum = {2'b00, step, ~step};
            4'd13:   dr_sum = {1'b0, step, ~step, 1'b0};
            4'd14:   dr_sum = {step, ~step, 2'b00};
            4'd15:   dr_sum = 4'd8;
            default: dr_sum = {2'b00, step, 1'b0};  // 0 or 2.
        endcase
        dr_result = {1'b0, eg_in} + {{(LEVEL_W - 3){1'b0}}, dr_sum};
    end

    // Attack decrement is a fraction of the current level.
    always_comb begin
        casez (rate[4:1])
            4'b1101: ar_sum0 = {1'b0, eg_in[LEVEL_W-1:3]};
            4'b111?: ar_sum0 = eg_in[LEVEL_W-1:2];
            default: ar_sum0 = {2'b00, eg_in[LEVEL_W-1:4]};
        endcase
        ar_sum1 = {1'b0, ar_sum0} + 1'b1;
        if (rate[4:3] == 2'b11) begin
            ar_sum = step ? {ar_sum1, 1'b0} : {1'b0, ar_sum1};  // Fast rates.
        end else begin
            ar_sum = step ? {1'b0, ar_sum1} : '0;
        end
        ar_result = {1'b0, eg_in} - {1'b0, ar_sum};
    end

    // Saturate, then apply instant attack.
    always_comb begin
        if (!sum_up) begin
            eg_held = eg_in;                                   // No tick this visit.
        end else if (attack) begin
            eg_held = ar_result[LEVEL_W] ? '0 : ar_result[LEVEL_W-1:0];
        end else begin
            eg_held = dr_result[LEVEL_W] ? LEVEL_MAX : dr_result[LEVEL_W-1:0];
        end
        eg_pure = (attack && rate == 5'h1F) ? '0 : eg_held;    // Rate 31 jumps.
    end

endmodule

// File: eg_timer.sv
/*
 * Global time base. Slot index steps every clock.
 * The sweep counter steps once per full sweep and wraps freely.
 */
`timescale 1ns/1ps

module eg_timer (
    input  logic                      clk,
    input  logic                      rst_n,
    output logic [eg_pkg::SLOT_W-1:0] slot,
    output logic [eg_pkg::CNT_W-1:0]  sweep_cnt
);
    import eg_pkg::*;

    logic sweep_end;

    // Last slot of the sweep is on this cycle.
    assign sweep_end = (slot == LAST_SLOT);

    // ==================================================
    // Slot and sweep counters
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot      <= '0;
            sweep_cnt <= '0;
        end else begin
            if (sweep_end) begin
                slot <= '0;                       // Back to the first slot.
            end else begin
                slot <= slot + 1'b1;
            end
            // Slot 0 of the next sweep sees the new count.
            if (sweep_end) begin
                sweep_cnt <= sweep_cnt + 1'b1;    // Wraps at the top.
            end
        end
    end

endmodule

// File: eg_sequencer.sv
/*
 * Per-slot envelope state machine, one slot per clock.
 * Each slot is revisited every NUM_SLOTS cycles, so no forwarding.
 * Key edges hold the level for one visit and only switch phase.
 */
`timescale 1ns/1ps

module eg_sequencer (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic [eg_pkg::SLOT_W-1:0]                   slot,
    input  logic [eg_pkg::CNT_W-1:0]                    sweep_cnt,
    input  eg_pkg::slot_cfg_t [eg_pkg::NUM_SLOTS-1:0]   cfg,
    output eg_pkg::eg_beat_t                            beat
);
    import eg_pkg::*;

    logic [LEVEL_W-1:0] level_q [NUM_SLOTS];   // Per-slot attenuation.
    eg_phase_e          phase_q [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] key_q;               // Previous key-on bit.

    slot_cfg_t          cur_cfg;
    logic [LEVEL_W-1:0] cur_level;
    eg_phase_e          cur_phase;
    logic               key_rise;
    logic               key_fall;
    logic [3:0]         rate4;
    logic [4:0]         rate;
    logic [3:0]         shift;
    logic [CNT_W-1:0]   low_mask;
    logic               step;
    logic               sum_up;
    logic               attack;
    logic [LEVEL_W-1:0] pure_level;
    logic [LEVEL_W-1:0] sus_level;
    logic [LEVEL_W-1:0] next_level;
    eg_phase_e          next_phase;

    assign cur_cfg   = cfg[slot];
    assign cur_level = level_q[slot];
    assign cur_phase = phase_q[slot];
    assign key_rise  = cur_cfg.key_on & ~key_q[slot];
    assign key_fall  = ~cur_cfg.key_on & key_q[slot];
    assign attack    = (cur_phase == ATTACK);
    assign sus_level = LEVEL_W'({cur_cfg.sl, 5'b0});   // sl x 32.

    // ==================================================
    // Rate select and tick rule
    // ==================================================
    always_comb begin
        case (cur_phase)
            ATTACK:  rate4 = cur_cfg.ar;
            DECAY:   rate4 = cur_cfg.dr;
            RELEASE: rate4 = cur_cfg.rr;
            default: rate4 = 4'd0;                      // Sustain never moves.
        endcase
        rate     = (rate4 == 4'd0) ? 5'd0 : {rate4, cur_cfg.ksr};
        shift    = (rate[4:1] < 4'd12) ? 4'd11 - rate[4:1] : 4'd0;
        low_mask = (CNT_W'(1) << shift) - CNT_W'(1);
        sum_up   = (rate != 5'd0) && ((sweep_cnt & low_mask) == '0);
        step     = sweep_cnt[shift] | (rate[1] & sweep_cnt[shift + 4'd1]);
    end

    eg_pure u_pure (
        .attack  (attack),
        .step    (step),
        .rate    (rate),
        .eg_in   (cur_level),
        .sum_up  (sum_up),
        .eg_pure (pure_level)
    );

    // Phase rules. Key edges win over arithmetic.
    always_comb begin
        next_level = pure_level;
        next_phase = cur_phase;
        if (key_rise) begin
            next_phase = ATTACK;
            next_level = cur_level;
        end else if (key_fall) begin
            next_phase = RELEASE;
            next_level = cur_level;
        end else begin
            case (cur_phase)
                ATTACK: begin
                    if (pure_level == '0) next_phase = DECAY;
                end
                DECAY: begin
                    if (pure_level >= sus_level) begin
                        next_level = sus_level;         // Clamp at the bound.
                        next_phase = SUSTAIN;
                    end
                end
                default: ;
            endcase
        end
    end

    // ==================================================
    // Slot memory and output beat
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                level_q[i] <= LEVEL_MAX;                // Silent.
                phase_q[i] <= RELEASE;
            end
            key_q <= '0;
            beat  <= '0;
        end else begin
            level_q[slot] <= next_level;
            phase_q[slot] <= next_phase;
            key_q[slot]   <= cur_cfg.key_on;
            beat.valid    <= 1'b1;
            beat.slot     <= slot;
            beat.phase    <= next_phase;
            beat.level    <= next_level;
        end
    end

endmodule

// File: eg_regs.sv
/*
 * AXI4-Lite slave for per-slot configuration, one word per slot.
 * One outstanding transaction, write wins when both arrive together.
 * Accepted writes land in cfg one clock after the handshake.
 */
`timescale 1ns/1ps

module eg_regs (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  eg_pkg::axil_req_t                         req,
    output eg_pkg::axil_rsp_t                         rsp,
    output eg_pkg::slot_cfg_t [eg_pkg::NUM_SLOTS-1:0] cfg
);
    import eg_pkg::*;

    axil_state_e            state_q;
    logic                   wr_fire;
    logic                   rd_fire;
    logic                   wr_hit;
    logic                   rd_hit;
    logic [SLOT_W-1:0]      wr_idx;
    logic [SLOT_W-1:0]      rd_idx;
    logic                   wr_en_q;    // Commit pending write.
    logic [SLOT_W-1:0]      wr_idx_q;
    logic [AXIL_DATA_W-1:0] wr_data_q;
    logic [AXIL_STRB_W-1:0] wr_strb_q;
    logic [AXIL_DATA_W-1:0] wr_word;
    logic [AXIL_DATA_W-1:0] old_word;
    logic [1:0]             b_resp_q;
    logic [1:0]             r_resp_q;
    logic [AXIL_DATA_W-1:0] r_data_q;

    function automatic logic [AXIL_DATA_W-1:0] cfg_word(input slot_cfg_t c);
        return {c.key_on, 14'd0, c.ksr, c.rr, c.sl, c.dr, c.ar};
    endfunction

    function automatic slot_cfg_t word_cfg(input logic [AXIL_DATA_W-1:0] w);
        slot_cfg_t c;
        c.ar     = w[3:0];
        c.dr     = w[7:4];
        c.sl     = w[11:8];
        c.rr     = w[15:12];
        c.ksr    = w[16];
        c.key_on = w[31];
        return c;
    endfunction

    // ==================================================
    // Decode and handshakes
    // ==================================================
    assign wr_hit  = (req.aw_addr < REG_SPAN);
    assign rd_hit  = (req.ar_addr < REG_SPAN);
    assign wr_idx  = req.aw_addr[SLOT_W+1:2];
    assign rd_idx  = req.ar_addr[SLOT_W+1:2];
    assign wr_fire = (state_q == IDLE) && req.aw_valid && req.w_valid;   // AW and W together.
    assign rd_fire = (state_q == IDLE) && req.ar_valid && !wr_fire;

    assign rsp.aw_ready = wr_fire;
    assign rsp.w_ready  = wr_fire;
    assign rsp.b_valid  = (state_q == WRITE_RESP);
    assign rsp.b_resp   = b_resp_q;
    assign rsp.ar_ready = rd_fire;
    assign rsp.r_valid  = (state_q == READ_RESP);
    assign rsp.r_data   = r_data_q;
    assign rsp.r_resp   = r_resp_q;

    // Byte-strobe merge over the current image.
    always_comb begin
        old_word = cfg_word(cfg[wr_idx_q]);
        for (int b = 0; b < AXIL_STRB_W; b++) begin
            wr_word[8*b +: 8] = wr_strb_q[b] ? wr_data_q[8*b +: 8] : old_word[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
            wr_en_q <= 1'b0;
            cfg     <= '0;
        end else begin
            wr_en_q <= wr_fire && wr_hit;               // Out of range writes nothing.
            if (wr_en_q) cfg[wr_idx_q] <= word_cfg(wr_word);
            case (state_q)
                IDLE: begin
                    if (wr_fire) state_q <= WRITE_RESP;
                    else if (rd_fire) state_q <= READ_RESP;
                end
                WRITE_RESP: if (req.b_ready) state_q <= IDLE;
                READ_RESP:  if (req.r_ready) state_q <= IDLE;
                default:    state_q <= IDLE;
            endcase
        end
    end

    // Captured payload and responses.
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            wr_idx_q  <= wr_idx;
            wr_data_q <= req.w_data;
            wr_strb_q <= req.w_strb;
            b_resp_q  <= wr_hit ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_fire) begin
            r_data_q <= rd_hit ? cfg_word(cfg[rd_idx]) : '0;  // Zero on miss.
            r_resp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

// File: eg_top.sv
/*
 * Envelope generator top. Four slots, one beat per clock.
 * Output stream has no ready, the sweep never stalls.
 */
`timescale 1ns/1ps

module eg_top (
    input  logic              clk,
    input  logic              rst_n,
    input  eg_pkg::axil_req_t req,
    output eg_pkg::axil_rsp_t rsp,
    output eg_pkg::eg_beat_t  beat
);
    import eg_pkg::*;

    slot_cfg_t [NUM_SLOTS-1:0] cfg;        // Live slot settings.
    logic [SLOT_W-1:0]         slot;       // Slot in process.
    logic [CNT_W-1:0]          sweep_cnt;

    eg_regs u_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rsp   (rsp),
        .cfg   (cfg)
    );

    eg_timer u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .slot      (slot),
        .sweep_cnt (sweep_cnt)
    );

    eg_sequencer u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .slot      (slot),
        .sweep_cnt (sweep_cnt),
        .cfg       (cfg),
        .beat      (beat)
    );

endmodule

// File: eg_scoreboard.sv
/*
 * Reference model of the envelope generator, fed by the AXI traffic.
 * Writes take effect on a slot visit two edges after the handshake.
 * Beats are compared on the falling edge, where they are stable.
 */
`timescale 1ns/1ps

module eg_scoreboard (
    input  logic              clk,
    input  logic              rst_n,
    input  eg_pkg::axil_req_t req,
    input  eg_pkg::axil_rsp_t rsp,
    input  eg_pkg::eg_beat_t  beat,
    output int                errors,
    output int                checked
);
    import eg_pkg::*;

    slot_cfg_t          mcfg   [NUM_SLOTS];
    logic [LEVEL_W-1:0] mlevel [NUM_SLOTS];
    eg_phase_e          mphase [NUM_SLOTS];
    logic               mkey   [NUM_SLOTS];
    logic [SLOT_W-1:0]  mslot;
    logic [CNT_W-1:0]   mcnt;
    logic               pend;                  // Write waiting to commit.
    logic [SLOT_W-1:0]  pend_idx;
    logic [31:0]        pend_data;
    logic [3:0]         pend_strb;
    eg_beat_t           exp_beat;
    logic               armed;

    // ==================================================
    // Reference model
    // ==================================================
    function automatic eg_beat_t expected_beat(input slot_cfg_t c, input logic [LEVEL_W-1:0] lvl,
                                               input eg_phase_e ph, input logic kp,
                                               input logic [CNT_W-1:0] cnt,
                                               input logic [SLOT_W-1:0] s);
        eg_beat_t b;
        int r4;
        int rate;
        int shift;
        int delta;
        int nl;
        logic stp;
        logic tick;
        r4 = (ph == ATTACK) ? c.ar : (ph == DECAY) ? c.dr : (ph == RELEASE) ? c.rr : 0;
        rate = (r4 == 0) ? 0 : r4 * 2 + c.ksr;
        shift = (r4 < 12) ? 11 - r4 : 0;
        tick = (rate != 0) && ((cnt % (1 << shift)) == 0);
        stp = cnt[shift] | (((rate / 2) % 2 == 1) && cnt[shift+1]);
        nl = lvl;
        if (tick && ph == ATTACK) begin
            delta = (r4 == 13) ? lvl / 8 : (r4 >= 14) ? lvl / 4 : lvl / 16;
            delta = delta + 1;
            if (r4 >= 12) delta = stp ? 2 * delta : delta;
            else delta = stp ? delta : 0;
            nl = (lvl < delta) ? 0 : lvl - delta;   // Floor at full volume.
        end else if (tick) begin
            if (r4 < 12) delta = stp ? 2 : 0;
            else if (r4 == 15) delta = 8;
            else delta = (stp ? 2 : 1) << (r4 - 12);
            nl = (lvl + delta > 1023) ? 1023 : lvl + delta;
        end
        if (ph == ATTACK && rate == 31) nl = 0;    // Instant attack.
        b.valid = 1'b1;
        b.slot  = s;
        b.phase = ph;
        if (c.key_on && !kp) begin
            b.phase = ATTACK;
            nl = lvl;
        end else if (!c.key_on && kp) begin
            b.phase = RELEASE;
            nl = lvl;
        end else if (ph == ATTACK && nl == 0) begin
            b.phase = DECAY;
        end else if (ph == DECAY && nl >= c.sl * 32) begin
            nl = c.sl * 32;
            b.phase = SUSTAIN;
        end
        b.level = nl;
        return b;
    endfunction

    function automatic logic [31:0] image(input slot_cfg_t c);
        return {c.key_on, 14'd0, c.ksr, c.rr, c.sl, c.dr, c.ar};
    endfunction

    function automatic slot_cfg_t from_image(input logic [31:0] w);
        slot_cfg_t c;
        c = {w[3:0], w[7:4], w[11:8], w[15:12], w[16], w[31]};
        return c;
    endfunction

    // ==================================================
    // Model update on the rising edge
    // ==================================================
    always @(posedge clk) begin
        logic [31:0] w;
        if (!rst_n) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                mcfg[i]   = '0;
                mlevel[i] = LEVEL_MAX;
                mphase[i] = RELEASE;
                mkey[i]   = 1'b0;
            end
            mslot    = '0;
            mcnt     = '0;
            pend     = 1'b0;
            exp_beat = '0;
            armed    = 1'b1;
        end else begin
            exp_beat = expected_beat(mcfg[mslot], mlevel[mslot], mphase[mslot],
                                     mkey[mslot], mcnt, mslot);
            mlevel[mslot] = exp_beat.level;
            mphase[mslot] = exp_beat.phase;
            mkey[mslot]   = mcfg[mslot].key_on;
            if (mslot == NUM_SLOTS - 1) mcnt = mcnt + 1'b1;
            mslot = mslot + 1'b1;
            if (pend) begin                         // Byte merge over current image.
                w = image(mcfg[pend_idx]);
                for (int b = 0; b < 4; b++) begin
                    if (pend_strb[b]) w[8*b +: 8] = pend_data[8*b +: 8];
                end
                mcfg[pend_idx] = from_image(w);
            end
            pend      = req.aw_valid && req.w_valid && rsp.aw_ready && (req.aw_addr < 16);
            pend_idx  = req.aw_addr[3:2];
            pend_data = req.w_data;
            pend_strb = req.w_strb;
        end
    end

    // Compare.
    initial begin
        errors  = 0;
        checked = 0;
        armed   = 1'b0;
    end

    always @(negedge clk) begin
        if (armed && !exp_beat.valid && beat.valid !== 1'b0) begin
            $display("Error at %0t: beat.valid expected 0 actual %b", $time, beat.valid);
            errors++;
        end else if (armed && exp_beat.valid) begin
            checked++;
            if (beat.valid !== 1'b1) begin
                $display("Error at %0t: beat.valid expected 1 actual %b", $time, beat.valid);
                errors++;
            end
            if (beat.slot !== exp_beat.slot) begin
                $display("Error at %0t: beat.slot expected %0d actual %0d",
                         $time, exp_beat.slot, beat.slot);
                errors++;
            end
            if (beat.phase !== exp_beat.phase) begin
                $display("Error at %0t: beat.phase expected %s actual %s",
                         $time, exp_beat.phase.name(), beat.phase.name());
                errors++;
            end
            if (beat.level !== exp_beat.level) begin
                $display("Error at %0t: beat.level expected %h actual %h",
                         $time, exp_beat.level, beat.level);
                errors++;
            end
        end
    end

endmodule

// File: eg_chk.sv
/*
 * Protocol and stream invariants for the envelope generator.
 * Bound into eg_top, watching the AXI response channels and the beats.
 */
`timescale 1ns/1ps

module eg_chk (
    input logic             clk,
    input logic             rst_n,
    input logic             b_valid,
    input logic             b_ready,
    input logic             r_valid,
    input logic             r_ready,
    input eg_pkg::eg_beat_t beat
);
    import eg_pkg::*;

    // Responses stay up until taken.
    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        b_valid && !b_ready |=> b_valid) else $error("BVALID dropped before BREADY");
    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        r_valid && !r_ready |=> r_valid) else $error("RVALID dropped before RREADY");

    // Slot index walks 0..3 with wrap.
    a_slot_step: assert property (@(posedge clk) disable iff (!rst_n)
        beat.valid && $past(beat.valid) |-> beat.slot == SLOT_W'($past(beat.slot) + 1))
        else $error("Beat slot did not advance by one");
    a_level_known: assert property (@(posedge clk) disable iff (!rst_n)
        beat.valid |-> !$isunknown(beat.level))
        else $error("Beat level unknown on a valid beat");

endmodule

bind eg_top eg_chk u_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .b_valid (rsp.b_valid),
    .b_ready (req.b_ready),
    .r_valid (rsp.r_valid),
    .r_ready (req.r_ready),
    .beat    (beat)
);

// File: tb_eg_top.sv
/*
 * Testbench for the envelope generator. Inputs change 0.5 ns after
 * the rising edge; outputs are read on the falling edge.
 */
`timescale 1ns/1ps

module tb_eg_top;
    import eg_pkg::*;

    logic        clk;
    logic        rst_n;
    axil_req_t   req;
    axil_rsp_t   rsp;
    eg_beat_t    beat;
    int          sb_errors;
    int          sb_checked;
    int          tb_errors;
    logic [31:0] rng;
    logic [31:0] shadow [NUM_SLOTS];       // Expected read-back image.
    logic [31:0] rdata;
    logic [1:0]  resp;
    int          waited;
    logic [9:0]  bound;
    logic [9:0]  prev_level;

    eg_top uut (.clk(clk), .rst_n(rst_n), .req(req), .rsp(rsp), .beat(beat));

    eg_scoreboard u_sb (.clk(clk), .rst_n(rst_n), .req(req), .rsp(rsp), .beat(beat),
                        .errors(sb_errors), .checked(sb_checked));

    always #2 clk = ~clk;                  // 4 ns period.

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] cfg_image(input int ar, input int dr, input int sl,
                                              input int rr, input bit ksr, input bit key);
        return {key, 14'd0, ksr, 4'(rr), 4'(sl), 4'(dr), 4'(ar)};
    endfunction

    task automatic abort_run(input string what);
        $display("Timeout waiting for %s", what);
        $display("Test failed");
        $finish;
    endtask

    task automatic tick_to_drive();
        @(posedge clk);
        #0.5;
    endtask

    // ==================================================
    // AXI4-Lite driver
    // ==================================================
    task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [1:0] r);
        int n;
        tick_to_drive();
        req.aw_addr  = addr;
        req.w_data   = data;
        req.w_strb   = strb;
        req.aw_valid = 1'b1;
        req.w_valid  = 1'b1;
        req.b_ready  = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            if (++n > 100) abort_run("AW/W handshake");
        end while (!(rsp.aw_ready && rsp.w_ready));
        tick_to_drive();
        req.aw_valid = 1'b0;
        req.w_valid  = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            if (++n > 100) abort_run("B response");
        end while (!rsp.b_valid);
        r = rsp.b_resp;
        tick_to_drive();
        req.b_ready = 1'b0;
        if (addr < 16) begin                // Mirror the byte merge.
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) shadow[addr[3:2]][8*b +: 8] = data[8*b +: 8];
            end
            shadow[addr[3:2]] &= 32'h8001_FFFF;
        end
    endtask

    task automatic axil_read(input logic [15:0] addr, output logic [31:0] d,
                             output logic [1:0] r);
        int n;
        tick_to_drive();
        req.ar_addr  = addr;
        req.ar_valid = 1'b1;
        req.r_ready  = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            if (++n > 100) abort_run("AR handshake");
        end while (!rsp.ar_ready);
        tick_to_drive();
        req.ar_valid = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            if (++n > 100) abort_run("R response");
        end while (!rsp.r_valid);
        d = rsp.r_data;
        r = rsp.r_resp;
        tick_to_drive();
        req.r_ready = 1'b0;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Error at %0t: %s expected %h actual %h", $time, name, exp, act);
            tb_errors++;
        end
    endtask

    task automatic report(input int num, input string what);
        $display("test %0d %s finished: tb errors %0d, scoreboard errors %0d",
                 num, what, tb_errors, sb_errors);
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        req = '0;
        tb_errors = 0;
        rng = 32'hcf9f;
        for (int i = 0; i < NUM_SLOTS; i++) shadow[i] = '0;
        repeat (3) @(posedge clk);
        #0.5 rst_n = 1'b1;

        // Silent state after reset.
        repeat (2) @(posedge clk);
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            check_value("beat.level", LEVEL_MAX, beat.level);
            check_value("beat.phase", RELEASE, beat.phase);
        end
        report(2, "reset state");

        // Read-back under random strobes, then SLVERR decode.
        for (int k = 0; k < 12; k++) begin
            rng = xorshift(rng);
            axil_write(16'(4 * (k % 4)), rng, 4'(rng >> 7), resp);
            check_value("b_resp", RESP_OKAY, resp);
            axil_read(16'(4 * (k % 4)), rdata, resp);
            check_value("r_resp", RESP_OKAY, resp);
            check_value("r_data", shadow[k % 4], rdata);
        end
        axil_write(16'h0010, 32'hFFFF_FFFF, 4'hF, resp);
        check_value("b_resp", RESP_SLVERR, resp);
        axil_read(16'h0010, rdata, resp);
        check_value("r_resp", RESP_SLVERR, resp);
        check_value("r_data", 32'd0, rdata);
        axil_read(16'h0000, rdata, resp);   // Miss must not alias onto slot 0.
        check_value("r_data", shadow[0], rdata);
        for (int i = 0; i < NUM_SLOTS; i++) axil_write(16'(4 * i), 32'd0, 4'hF, resp);
        report(1, "register read-back");

        // Instant attack on slot 2.
        axil_write(16'h0008, cfg_image(15, 0, 0, 0, 1, 1), 4'hF, resp);
        waited = 0;
        do begin
            @(negedge clk);
            if (++waited > 64) abort_run("slot 2 attack");
        end while (!(beat.slot == 2 && beat.phase == DECAY && beat.level == 0));
        report(3, "instant attack");

        // Decay to sustain on slot 1.
        rng = xorshift(rng);
        bound = 10'((1 + rng % 15) * 32);
        axil_write(16'h0004, cfg_image(15, 10 + (rng >> 8) % 6, 1 + rng % 15, 0, 1, 1),
                   4'hF, resp);
        waited = 0;
        do begin
            @(negedge clk);
            if (++waited > 40000) abort_run("slot 1 sustain");
            if (beat.slot == 1 && beat.phase inside {DECAY, SUSTAIN} && beat.level > bound) begin
                $display("Error at %0t: beat.level expected <= %h actual %h",
                         $time, bound, beat.level);
                tb_errors++;
            end
        end while (!(beat.slot == 1 && beat.phase == SUSTAIN));
        check_value("beat.level", bound, beat.level);
        report(4, "decay to sustain");

        // Key-off with the fastest release.
        axil_write(16'h0004, cfg_image(15, 0, 0, 15, 1, 0), 4'hF, resp);
        prev_level = bound;
        waited = 0;
        do begin
            @(negedge clk);
            if (++waited > 5000) abort_run("slot 1 release");
            if (beat.slot == 1 && beat.phase == RELEASE) begin
                if (beat.level < prev_level) begin
                    $display("Error at %0t: beat.level fell from %h to %h in release",
                             $time, prev_level, beat.level);
                    tb_errors++;
                end
                prev_level = beat.level;
            end
        end while (!(beat.slot == 1 && beat.phase == RELEASE && beat.level == LEVEL_MAX));
        report(5, "release");

        // Random traffic on every slot; the scoreboard checks each beat.
        for (int round = 0; round < 6; round++) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                rng = xorshift(rng);
                axil_write(16'(4 * i), rng & 32'h8001_FFFF, 4'hF, resp);
            end
            repeat (1500) @(posedge clk);
        end
        report(6, "random slots");

        $display("Counts: %0d beats compared, %0d scoreboard errors, %0d testbench errors",
                 sb_checked, sb_errors, tb_errors);
        if (sb_errors == 0 && tb_errors == 0 && sb_checked > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: eg_top.f
eg_pkg.sv
eg_pure.sv
eg_timer.sv
eg_sequencer.sv
eg_regs.sv
eg_top.sv
eg_scoreboard.sv
eg_chk.sv
tb_eg_top.sv

// File: Bender.yml
package:
  name: eg_top

sources:
  - eg_pkg.sv
  - eg_pure.sv
  - eg_timer.sv
  - eg_sequencer.sv
  - eg_regs.sv
  - eg_top.sv
  - target: test
    files:
      - eg_scoreboard.sv
      - eg_chk.sv
      - tb_eg_top.sv
